//--- Bender.yml
package:
  name: night_scene

sources:
  - logic/night_pkg.sv
  - logic/night_cycle.sv
  - logic/star_lfsr.sv
  - logic/night_sky.sv
  - logic/sky_pixel.sv
  - logic/night_scene.sv
  - target: test
    files:
      - verif/night_scene_props.sv
      - verif/night_scene_tb.sv

//--- logic/night_cycle.sv
module night_cycle (
    input  logic       clk,
    input  logic       rst,
    input  logic       frame,
    output logic [7:0] night_rate
);
    import night_pkg::*;

    logic rising; // ramp direction.

    // ramp up to rate_max, back down to 0, and again.
    // one full day/night lasts 2 * rate_max frames.
    always_ff @(posedge clk) begin
        if (rst) begin
            night_rate <= '0;
            rising <= 1'b1;
        end else if (frame) begin
            if (rising) begin
                if (night_rate > rate_max - rate_step) begin
                    rising <= 1'b0; // top reached, turn around.
                    night_rate <= night_rate - rate_step;
                end else begin
                    night_rate <= night_rate + rate_step;
                end
            end else begin
                if (night_rate < rate_step) begin
                    rising <= 1'b1; // bottom reached.
                    night_rate <= night_rate + rate_step;
                end else begin
                    night_rate <= night_rate - rate_step;
                end
            end
        end
    end

endmodule

//--- logic/night_pkg.sv
package night_pkg;

    // playfield and fixed-point scale.
    localparam int game_width = 640;
    localparam int speed_scale = 1024; // game units per pixel.

    // night is shown while the rate is above this.
    localparam logic [7:0] visible_rate = 8'd130;

    // moon box.
    localparam int moon_init_x = game_width - 50;
    localparam int moon_y = 30;
    localparam int moon_h = 40;
    localparam int moon_w = 20;

    // game units per frame.
    localparam int moon_speed = 256;
    localparam int star_speed = 307;

    localparam int num_stars = 2;
    localparam int segment_size = game_width / num_stars;
    localparam int star_size = 9;
    localparam int star_max_y = 70;

    localparam int num_phases = 7;
    localparam int full_phase = 3; // moon is twice as wide here.

    // triangle ramp of the day/night rate.
    localparam logic [7:0] rate_step = 8'd1;
    localparam logic [7:0] rate_max = 8'd255;

    // galois lfsr for the star offsets.
    localparam logic [15:0] lfsr_seed = 16'hace1;
    localparam logic [15:0] lfsr_taps = 16'hb400;

    localparam logic [11:0] col_moon = 12'hffd;
    localparam logic [11:0] col_star = 12'hfff;
    localparam logic [11:0] col_night = 12'h113;
    localparam logic [11:0] col_day = 12'h8cf;

endpackage

//--- logic/night_scene.sv
module night_scene (
    input  logic               clk,
    input  logic               rst,
    input  logic               frame,
    input  logic               crash,
    input  logic               query_valid,
    output logic               query_ready,
    input  logic [9:0]         query_x,
    input  logic [9:0]         query_y,
    output logic               pix_valid,
    input  logic               pix_ready,
    output logic [11:0]        pix_color,
    output logic               night_active,
    output logic [7:0]         night_rate,
    output logic signed [10:0] moon_x,
    output logic [2:0]         moon_phase,
    output logic signed [10:0] star_x [night_pkg::num_stars],
    output logic [9:0]         star_y [night_pkg::num_stars]
);
    import night_pkg::*;

    logic [7:0] star_x_rand [num_stars];
    logic [5:0] star_y_rand [num_stars];
    logic [9:0] moon_width;

    night_cycle i_night_cycle (
        .clk        (clk),
        .rst        (rst),
        .frame      (frame),
        .night_rate (night_rate)
    );

    star_lfsr i_star_lfsr (
        .clk         (clk),
        .rst         (rst),
        .frame       (frame),
        .star_x_rand (star_x_rand),
        .star_y_rand (star_y_rand)
    );

    night_sky i_night_sky (
        .clk          (clk),
        .rst          (rst),
        .frame        (frame),
        .crash        (crash),
        .night_rate   (night_rate),
        .star_x_rand  (star_x_rand),
        .star_y_rand  (star_y_rand),
        .night_active (night_active),
        .moon_x       (moon_x),
        .moon_width   (moon_width),
        .moon_phase   (moon_phase),
        .star_x       (star_x),
        .star_y       (star_y)
    );

    sky_pixel i_sky_pixel (
        .clk          (clk),
        .rst          (rst),
        .query_valid  (query_valid),
        .query_ready  (query_ready),
        .query_x      (query_x),
        .query_y      (query_y),
        .night_active (night_active),
        .moon_x       (moon_x),
        .moon_width   (moon_width),
        .star_x       (star_x),
        .star_y       (star_y),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .pix_color    (pix_color)
    );

endmodule

//--- logic/night_sky.sv
module night_sky (
    input  logic               clk,
    input  logic               rst,
    input  logic               frame,
    input  logic               crash,
    input  logic [7:0]         night_rate,
    input  logic [7:0]         star_x_rand [night_pkg::num_stars],
    input  logic [5:0]         star_y_rand [night_pkg::num_stars],
    output logic               night_active,
    output logic signed [10:0] moon_x,
    output logic [9:0]         moon_width,
    output logic [2:0]         moon_phase,
    output logic signed [10:0] star_x [night_pkg::num_stars],
    output logic [9:0]         star_y [night_pkg::num_stars]
);
    import night_pkg::*;

    // positions in game units, moon_x and star_x are these scaled down.
    logic signed [20:0] moon_x_game;
    logic signed [20:0] star_x_game [num_stars];
    logic               night_now;
    logic signed [20:0] moon_x_next;
    logic signed [20:0] star_x_next [num_stars];

    // one step left, wrapping to the right edge once fully off screen.
    function automatic logic signed [20:0] step_x(
        input logic signed [20:0] x,
        input logic signed [20:0] speed
    );
        logic signed [20:0] moved;
        moved = x - speed;
        if (moved < -(2 * moon_w * speed_scale)) begin
            return 21'(game_width * speed_scale);
        end
        return moved;
    endfunction

    function automatic logic signed [10:0] to_pixel(input logic signed [20:0] x);
        return 11'(x / speed_scale); // truncates toward zero.
    endfunction

    assign night_now = night_rate > visible_rate;
    assign moon_width = (moon_phase == 3'(full_phase)) ? 10'(2 * moon_w) : 10'(moon_w);

    always_comb begin
        moon_x_next = step_x(moon_x_game, 21'(moon_speed));
        for (int i = 0; i < num_stars; i++) begin
            star_x_next[i] = step_x(star_x_game[i], 21'(star_speed));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            night_active <= 1'b0;
            moon_phase <= 3'(num_phases - 1);
            moon_x_game <= 21'(moon_init_x * speed_scale);
            moon_x <= 11'(moon_init_x);
            star_x_game <= '{default: '0};
            star_x <= '{default: '0};
            star_y <= '{default: '0};
        end else if (frame) begin
            if (!night_active && night_now) begin
                // night begins, next moon phase and fresh stars.
                night_active <= 1'b1;
                if (moon_phase == 3'(num_phases - 1)) begin
                    moon_phase <= '0;
                end else begin
                    moon_phase <= moon_phase + 3'd1;
                end
                for (int i = 0; i < num_stars; i++) begin
                    star_x_game[i] <= 21'((segment_size * i + star_x_rand[i]) * speed_scale);
                    star_x[i] <= 11'(segment_size * i + star_x_rand[i]);
                    star_y[i] <= 10'(star_y_rand[i]); // 6 bits, always within star_max_y.
                end
            end else if (!night_now) begin
                night_active <= 1'b0;
            end

            // motion stops on a crash.
            if (night_active && !crash) begin
                moon_x_game <= moon_x_next;
                moon_x <= to_pixel(moon_x_next);
                for (int i = 0; i < num_stars; i++) begin
                    star_x_game[i] <= star_x_next[i];
                    star_x[i] <= to_pixel(star_x_next[i]);
                end
            end
        end
    end

endmodule

//--- logic/sky_pixel.sv
module sky_pixel (
    input  logic               clk,
    input  logic               rst,
    input  logic               query_valid,
    output logic               query_ready,
    input  logic [9:0]         query_x,
    input  logic [9:0]         query_y,
    input  logic               night_active,
    input  logic signed [10:0] moon_x,
    input  logic [9:0]         moon_width,
    input  logic signed [10:0] star_x [night_pkg::num_stars],
    input  logic [9:0]         star_y [night_pkg::num_stars],
    output logic               pix_valid,
    input  logic               pix_ready,
    output logic [11:0]        pix_color
);
    import night_pkg::*;

    logic        take;
    logic [11:0] color;
    logic        in_star;

    // left and top edges inside, right and bottom edges outside.
    function automatic logic in_box(
        input logic signed [11:0] px,
        input logic [10:0]        py,
        input logic signed [11:0] bx,
        input logic [10:0]        by,
        input logic [10:0]        bw,
        input logic [10:0]        bh
    );
        return px >= bx && px < bx + $signed({1'b0, bw}) && py >= by && py < by + bh;
    endfunction

    assign query_ready = !pix_valid || pix_ready;
    assign take = query_valid && query_ready;

    always_comb begin
        in_star = 1'b0;
        for (int i = 0; i < num_stars; i++) begin
            in_star |= in_box($signed({2'b00, query_x}), {1'b0, query_y}, 12'(star_x[i]),
                {1'b0, star_y[i]}, 11'(star_size), 11'(star_size));
        end
        if (!night_active) begin
            color = col_day;
        end else if (in_box($signed({2'b00, query_x}), {1'b0, query_y}, 12'(moon_x),
                11'(moon_y), {1'b0, moon_width}, 11'(moon_h))) begin
            color = col_moon; // moon covers the stars.
        end else if (in_star) begin
            color = col_star;
        end else begin
            color = col_night;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_valid <= 1'b0;
        end else if (take) begin
            pix_valid <= 1'b1;
        end else if (pix_ready) begin
            pix_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pix_color <= color; // held while the answer waits.
        end
    end

endmodule

//--- logic/star_lfsr.sv
module star_lfsr (
    input  logic       clk,
    input  logic       rst,
    input  logic       frame,
    output logic [7:0] star_x_rand [night_pkg::num_stars],
    output logic [5:0] star_y_rand [night_pkg::num_stars]
);
    import night_pkg::*;

    logic [15:0] lfsr;

    // right shift, fold the taps back in when a one drops out.
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= lfsr_seed;
        end else if (frame) begin
            lfsr <= (lfsr >> 1) ^ (lfsr[0] ? lfsr_taps : 16'h0000);
        end
    end

    // star i gets x from byte i and y from the i-th 6-bit field.
    always_comb begin
        for (int i = 0; i < num_stars; i++) begin
            star_x_rand[i] = lfsr[8*i +: 8];
            star_y_rand[i] = lfsr[6*i +: 6];
        end
    end

endmodule

//--- verif/night_scene_props.sv
module night_scene_props (
    input logic        clk,
    input logic        rst,
    input logic        frame,
    input logic        night_active,
    input logic [2:0]  moon_phase,
    input logic        pix_valid,
    input logic        pix_ready,
    input logic [11:0] pix_color
);
    import night_pkg::*;

    pix_clear: assert property (@(posedge clk) rst |=> !pix_valid)
        else $error("pix_valid still high after reset");

    // a waiting answer keeps its colour.
    pix_hold: assert property (@(posedge clk) disable iff (rst)
        pix_valid && !pix_ready |=> $stable(pix_color))
        else $error("pix_color changed while the answer waited");

    phase_range: assert property (@(posedge clk) disable iff (rst) moon_phase < num_phases)
        else $error("moon_phase out of range");

    night_on_frame: assert property (@(posedge clk) disable iff (rst)
        $rose(night_active) |-> $past(frame))
        else $error("night_active rose without a frame");

endmodule

bind night_scene night_scene_props i_night_scene_props (.*);

//--- verif/night_scene_tb.sv
module night_scene_tb;
    import night_pkg::*;

    localparam int num_frames = 10000; // enough nights for the moon to wrap past the left edge.
    localparam int frame_gap = 3;
    localparam int timeout_cycles = 3 * num_frames * frame_gap + 2000;

    logic clk, rst, frame, crash;
    logic query_valid, query_ready, pix_valid, pix_ready, night_active;
    logic [9:0] query_x, query_y;
    logic [11:0] pix_color;
    logic [7:0] night_rate;
    logic signed [10:0] moon_x;
    logic [2:0] moon_phase;
    logic signed [10:0] star_x [num_stars];
    logic [9:0] star_y [num_stars];

    // reference model of the sky.
    logic [7:0] m_rate;
    logic [15:0] m_lfsr;
    logic m_rising, m_active;
    logic [2:0] m_phase;
    int m_moon_g;
    int m_star_g [num_stars];
    int m_star_y [num_stars];
    logic m_pix_valid; // answer register of the pixel stage.

    logic [11:0] answers [$]; // expected colours in query order.
    logic query_took, check_due;
    int wide_hits, moon_wraps, crash_left, cycles;

    night_scene i_night_scene (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rate(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pos(input string name, input logic signed [10:0] got,
            input logic signed [10:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_phase(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_color(input string name, input logic [11:0] got, input logic [11:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_row(input string name, input logic [9:0] got, input logic [9:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic int move_left(input int x, input int speed);
        if (x - speed < -2 * moon_w * speed_scale) begin
            return game_width * speed_scale; // gone past the left edge.
        end
        return x - speed;
    endfunction

    // one frame of the sky, using the rate and lfsr from before their step.
    function automatic void model_frame(input logic crash_now);
        logic was_active;
        logic dark;
        int moved;
        was_active = m_active;
        dark = m_rate > visible_rate;
        if (!m_active && dark) begin
            m_active = 1'b1;
            m_phase = 3'((int'(m_phase) + 1) % num_phases);
            for (int i = 0; i < num_stars; i++) begin
                m_star_g[i] = (segment_size * i + int'(m_lfsr[8*i +: 8])) * speed_scale;
                m_star_y[i] = int'(m_lfsr[6*i +: 6]) % 64;
            end
        end else if (!dark) begin
            m_active = 1'b0;
        end
        if (was_active && !crash_now) begin
            moved = move_left(m_moon_g, moon_speed);
            if (moved > m_moon_g) begin
                moon_wraps++;
            end
            m_moon_g = moved;
            for (int i = 0; i < num_stars; i++) begin
                m_star_g[i] = move_left(m_star_g[i], star_speed);
            end
        end
        if (m_rising && m_rate == rate_max) begin
            m_rising = 1'b0;
        end else if (!m_rising && m_rate == 8'd0) begin
            m_rising = 1'b1;
        end
        m_rate = m_rising ? m_rate + rate_step : m_rate - rate_step;
        m_lfsr = (m_lfsr >> 1) ^ (m_lfsr[0] ? lfsr_taps : 16'h0000);
    endfunction

    function automatic logic inside_box(input int px, input int py, input int bx,
            input int by, input int bw, input int bh);
        return px >= bx && px < bx + bw && py >= by && py < by + bh;
    endfunction

    function automatic logic [11:0] expect_color(input int qx, input int qy);
        int width;
        width = (m_phase == 3'(full_phase)) ? 2 * moon_w : moon_w;
        if (!m_active) begin
            return col_day;
        end
        if (inside_box(qx, qy, m_moon_g / speed_scale, moon_y, width, moon_h)) begin
            return col_moon;
        end
        for (int i = 0; i < num_stars; i++) begin
            if (inside_box(qx, qy, m_star_g[i] / speed_scale, m_star_y[i],
                    star_size, star_size)) begin
                return col_star;
            end
        end
        return col_night;
    endfunction

    task automatic compare_state();
        check_rate("night_rate", night_rate, m_rate);
        check_flag("night_active", night_active, m_active);
        check_phase("moon_phase", moon_phase, m_phase);
        check_pos("moon_x", moon_x, 11'(m_moon_g / speed_scale));
        for (int i = 0; i < num_stars; i++) begin
            check_pos($sformatf("star_x[%0d]", i), star_x[i], 11'(m_star_g[i] / speed_scale));
            check_row($sformatf("star_y[%0d]", i), star_y[i], 10'(m_star_y[i]));
        end
    endtask

    // falling edge, where inputs and outputs have settled.
    always @(negedge clk) begin
        if (rst) begin
            m_rate = '0;
            m_rising = 1'b1;
            m_lfsr = lfsr_seed;
            m_active = 1'b0;
            m_phase = 3'(num_phases - 1);
            m_moon_g = moon_init_x * speed_scale;
            m_star_g = '{default: 0};
            m_star_y = '{default: 0};
            m_pix_valid = 1'b0;
            answers.delete();
            query_took = 1'b0;
            check_due = 1'b0;
        end else begin
            if (check_due) begin
                compare_state(); // one cycle after the frame.
            end
            check_flag("pix_valid", pix_valid, m_pix_valid);
            check_flag("query_ready", query_ready, !m_pix_valid || pix_ready);
            if (pix_valid && pix_ready) begin
                if (answers.size() == 0) begin
                    $display("an answer came out with no query pending");
                    abort_run();
                end else begin
                    check_color("pix_color", pix_color, answers.pop_front());
                end
            end
            query_took = query_valid && (!m_pix_valid || pix_ready);
            if (query_took) begin
                answers.push_back(expect_color(query_x, query_y));
                if (answers[$] == col_moon && m_phase == 3'(full_phase)
                        && int'(query_x) >= m_moon_g / speed_scale + moon_w) begin
                    wide_hits++;
                end
            end
            m_pix_valid = query_took || (m_pix_valid && !pix_ready);
            check_due = frame;
            if (frame) begin
                model_frame(crash);
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("timeout after %0d cycles, the run never finished", cycles);
                abort_run();
            end
        end
    end

    task automatic next_query();
        int mode;
        int k;
        int qx;
        int qy;
        if (query_valid && !query_took) begin
            return; // held until the transfer.
        end
        mode = $urandom_range(0, 3);
        k = $urandom_range(0, num_stars - 1);
        if (mode == 0) begin
            query_valid = 1'b0;
            return;
        end else if (mode == 1) begin
            qx = int'(moon_x) + int'($urandom_range(0, 50)) - 5;
            qy = $urandom_range(moon_y - 5, moon_y + moon_h + 5);
        end else if (mode == 2) begin
            qx = int'(star_x[k]) + int'($urandom_range(0, 14)) - 3;
            qy = int'(star_y[k]) + int'($urandom_range(0, 14)) - 3;
        end else begin
            qx = $urandom_range(0, game_width - 1);
            qy = $urandom_range(0, 99);
        end
        query_valid = 1'b1;
        query_x = 10'(qx < 0 ? 0 : qx);
        query_y = 10'(qy < 0 ? 0 : qy);
    endtask

    initial begin
        void'($urandom(32'he1a8));
        rst = 1'b1;
        frame = 1'b0;
        crash = 1'b0;
        query_valid = 1'b0;
        query_x = '0;
        query_y = '0;
        pix_ready = 1'b0;
        wide_hits = 0;
        moon_wraps = 0;
        crash_left = 0;
        repeat (4) @(posedge clk);
        #5 rst = 1'b0;
        for (int f = 0; f < num_frames; f++) begin
            for (int g = 0; g < frame_gap; g++) begin
                @(posedge clk);
                #5;
                frame = (g == 0);
                if (g == 0) begin
                    if (crash_left == 0 && $urandom_range(0, 99) < 2) begin
                        crash_left = $urandom_range(4, 40); // frames of frozen motion.
                    end
                    crash = crash_left > 0;
                    if (crash_left > 0) begin
                        crash_left--;
                    end
                end
                pix_ready = $urandom_range(0, 3) != 0;
                next_query();
            end
        end
        @(posedge clk);
        #5;
        frame = 1'b0;
        crash = 1'b0;
        pix_ready = 1'b1;
        while (query_valid && !query_took) begin
            @(posedge clk);
            #5;
        end
        query_valid = 1'b0;
        while (pix_valid || answers.size() != 0) begin
            @(posedge clk);
            #5;
        end
        if (wide_hits == 0 || moon_wraps == 0) begin
            $display("missed a case: %0d full moon right half hits, %0d moon wraps",
                wide_hits, moon_wraps);
            abort_run();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- vlog.f
logic/night_pkg.sv
logic/night_cycle.sv
logic/star_lfsr.sv
logic/night_sky.sv
logic/sky_pixel.sv
logic/night_scene.sv
verif/night_scene_props.sv
verif/night_scene_tb.sv
